// ==== files.f ====
rtl/clock_pkg.sv
rtl/tick_prescaler.sv
rtl/time_counter.sv
rtl/time_to_segment.sv
rtl/time_displayer.sv
rtl/digital_clock_top.sv
test/clock_gen.sv
test/digital_clock_tb.sv

// ==== Makefile ====
TOP := digital_clock_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f

# Pass only when the testbench printed its pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

// ==== test/digital_clock_tb.sv ====
module digital_clock_tb;

    localparam int TICK_DIV    = 400;
    localparam int SCAN_DIV    = 4;
    localparam int DRIVE_DELAY = 2;
    localparam int SEED        = 78826;
    // Roughly twice the ~30k cycles the sequence below needs
    localparam int MAX_CYCLES  = 60_000;

    logic       clk_src;
    logic       rst;
    logic       set_valid;
    logic [4:0] set_hour;
    logic [5:0] set_min;
    logic [5:0] set_sec;
    logic [7:0] anodes;
    logic [7:0] cathodes;

    // Reference model state, updated on every rising edge
    int start_h = 0;
    int start_m = 0;
    int start_s = 0;
    int cycles = 0;
    int scan_cnt = 0;
    int tick_total = 0;
    // State behind the registered outputs of the latest edge
    int shown_h = 0;
    int shown_m = 0;
    int shown_s = 0;
    int shown_cycles = 0;
    int shown_scan = 0;
    bit out_reset = 1'b1;
    bit model_ready = 1'b0;

    int cycle_count = 0;

    clock_gen #(
        .PERIOD       (20),
        .RESET_CYCLES (5),
        .DRIVE_DELAY  (DRIVE_DELAY)
    ) clock_gen_inst (
        .clk_src (clk_src),
        .rst     (rst)
    );

    digital_clock_top #(
        .TICK_DIV (TICK_DIV),
        .SCAN_DIV (SCAN_DIV)
    ) digital_clock_top_inst (
        .clk_src   (clk_src),
        .rst       (rst),
        .set_valid (set_valid),
        .set_hour  (set_hour),
        .set_min   (set_min),
        .set_sec   (set_sec),
        .anodes    (anodes),
        .cathodes  (cathodes)
    );

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Active low segments a to g with the decimal point off
    function automatic logic [7:0] digit_pattern(input int d);
        logic [7:0] pat;
        case (d)
            0: pat = 8'hC0;
            1: pat = 8'hF9;
            2: pat = 8'hA4;
            3: pat = 8'hB0;
            4: pat = 8'h99;
            5: pat = 8'h92;
            6: pat = 8'h82;
            7: pat = 8'hF8;
            8: pat = 8'h80;
            9: pat = 8'h90;
            default: pat = 8'hFF;
        endcase
        return pat;
    endfunction

    function automatic bit load_in_range(input int h, input int m, input int s);
        return (h <= 23) && (m <= 59) && (s <= 59);
    endfunction

    // Time after a number of ticks and the pattern one slot shows for it
    function automatic logic [7:0] ref_cathode(input int h0, input int m0, input int s0,
                                               input int ticks, input int slot);
        int sod;
        int field;
        logic [7:0] pat;
        sod = (h0 * 3600 + m0 * 60 + s0 + ticks) % 86400;
        case (slot / 2)
            0: field = sod % 60;
            1: field = (sod / 60) % 60;
            default: field = sod / 3600;
        endcase
        if (slot >= 6) begin
            pat = clock_pkg::SEG_BLANK;
        end else if (slot % 2 == 0) begin
            pat = digit_pattern(field % 10);
        end else begin
            pat = digit_pattern(field / 10);
        end
        return pat;
    endfunction

    always @(posedge clk_src) begin
        shown_h      = start_h;
        shown_m      = start_m;
        shown_s      = start_s;
        shown_cycles = cycles;
        shown_scan   = scan_cnt;
        out_reset    = rst;
        if (rst) begin
            start_h  = 0;
            start_m  = 0;
            start_s  = 0;
            cycles   = 0;
            scan_cnt = 0;
        end else begin
            scan_cnt++;
            if (set_valid && load_in_range(int'(set_hour), int'(set_min), int'(set_sec))) begin
                start_h = int'(set_hour);
                start_m = int'(set_min);
                start_s = int'(set_sec);
                cycles  = 0;
            end else begin
                cycles++;
                if (cycles % TICK_DIV == 0) begin
                    tick_total++;
                end
            end
        end
        model_ready = 1'b1;
    end

    //////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("Errors found");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // Index of the single low anode bit or -1 when not exactly one is low
    function automatic int active_slot(input logic [7:0] an);
        int slot;
        int lows;
        slot = -1;
        lows = 0;
        for (int k = 0; k < clock_pkg::NUM_SLOTS; k++) begin
            if (((an >> k) & 8'h01) == 8'h00) begin
                lows++;
                slot = k;
            end
        end
        if (lows != 1) begin
            slot = -1;
        end
        return slot;
    endfunction

    // Outputs are stable half a period after the edge
    always @(negedge clk_src) begin : compare_outputs
        int exp_slot;
        int act_slot;
        logic [7:0] exp_cath;
        if (model_ready) begin
            if (out_reset) begin
                check_value(32'(anodes), 32'hFF, "anodes not dark in reset");
                check_value(32'(cathodes), 32'hFF, "cathodes not dark in reset");
            end else begin
                exp_slot = (shown_scan / SCAN_DIV) % clock_pkg::NUM_SLOTS;
                act_slot = active_slot(anodes);
                check_value(act_slot, exp_slot, "active slot");
                exp_cath = ref_cathode(shown_h, shown_m, shown_s,
                                       shown_cycles / TICK_DIV, exp_slot);
                check_value(32'(cathodes), 32'(exp_cath), "cathodes for active slot");
            end
        end
    end

    always @(posedge clk_src) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the test sequence did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $fatal(1, "simulation timed out");
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // All stimulus tasks start and end 2 units after a rising edge
    task automatic drive_load(input int h, input int m, input int s);
        set_hour  = 5'(h);
        set_min   = 6'(m);
        set_sec   = 6'(s);
        set_valid = 1'b1;
        @(posedge clk_src);
        #DRIVE_DELAY;
        set_valid = 1'b0;
    endtask

    task automatic drive_rejected_load();
        int pick;
        int h;
        int m;
        int s;
        pick = int'($urandom % 3);
        h = int'($urandom % 24);
        m = int'($urandom % 60);
        s = int'($urandom % 60);
        case (pick)
            0: s = 60 + int'($urandom % 4);
            1: m = 60 + int'($urandom % 4);
            default: h = 24 + int'($urandom % 8);
        endcase
        drive_load(h, m, s);
    endtask

    task automatic wait_ticks(input int n);
        int target;
        target = tick_total + n;
        while (tick_total < target) begin
            @(negedge clk_src);
        end
        @(posedge clk_src);
        #DRIVE_DELAY;
    endtask

    task automatic wait_full_scan();
        repeat (clock_pkg::NUM_SLOTS * SCAN_DIV) @(posedge clk_src);
        #DRIVE_DELAY;
    endtask

    initial begin : stimulus
        int h;
        int m;
        int s;
        void'($urandom(SEED));
        set_valid = 1'b0;
        set_hour  = '0;
        set_min   = '0;
        set_sec   = '0;
        @(negedge rst);
        @(posedge clk_src);
        #DRIVE_DELAY;

        // Free running from 00:00:00
        wait_ticks(40);
        wait_full_scan();

        // Minute carry, hour carry, midnight
        drive_load(0, 58, 57);
        wait_ticks(4);
        wait_full_scan();
        drive_load(9, 59, 58);
        wait_ticks(4);
        wait_full_scan();
        drive_load(23, 59, 58);
        wait_ticks(4);
        wait_full_scan();

        // Out of range requests leave the cadence running
        repeat (4) begin
            repeat (1 + $urandom % 150) @(posedge clk_src);
            #DRIVE_DELAY;
            drive_rejected_load();
        end
        wait_ticks(2);
        wait_full_scan();

        repeat (20) begin
            h = int'($urandom % 24);
            m = int'($urandom % 60);
            s = int'($urandom % 60);
            drive_load(h, m, s);
            wait_full_scan();
            wait_ticks(1);
        end
        wait_full_scan();

        $display("No errors");
        $finish;
    end

endmodule

// ==== test/clock_gen.sv ====
module clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 5,
    parameter int DRIVE_DELAY  = 2
) (
    output logic clk_src,
    output logic rst
);

    initial begin
        clk_src = 1'b0;
        forever #(PERIOD / 2) clk_src = ~clk_src;
    end

    // Release lands just after a rising edge as every other input does
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_src);
        #DRIVE_DELAY;
        rst = 1'b0;
    end

endmodule

// ==== rtl/digital_clock_top.sv ====
module digital_clock_top #(
    parameter int TICK_DIV = 50_000_000,
    parameter int SCAN_DIV = 100_000
) (
    input  logic       clk_src,
    input  logic       rst,
    input  logic       set_valid,
    input  logic [4:0] set_hour,
    input  logic [5:0] set_min,
    input  logic [5:0] set_sec,
    output logic [7:0] anodes,
    output logic [7:0] cathodes
);

    logic                                             tick;
    logic                                             load;
    clock_pkg::time_val_t                             set_hour_ext;
    clock_pkg::time_val_t [clock_pkg::NUM_FIELDS-1:0] fields;
    clock_pkg::seg_pair_t [clock_pkg::NUM_FIELDS-1:0] seg_pairs;

    // Hour port is one bit narrower than a field
    assign set_hour_ext = {1'b0, set_hour};

    //////////////////////////////////////////////////
    // Timekeeping
    //////////////////////////////////////////////////

    tick_prescaler #(
        .TICK_DIV (TICK_DIV)
    ) tick_prescaler_inst (
        .clk_src (clk_src),
        .rst     (rst),
        .restart (load),
        .tick    (tick)
    );

    time_counter time_counter_inst (
        .clk_src   (clk_src),
        .rst       (rst),
        .tick      (tick),
        .set_valid (set_valid),
        .set_hour  (set_hour_ext),
        .set_min   (set_min),
        .set_sec   (set_sec),
        .load      (load),
        .fields    (fields)
    );

    //////////////////////////////////////////////////
    // Display path
    //////////////////////////////////////////////////

    // One decoder per field, seconds first
    for (genvar i = 0; i < clock_pkg::NUM_FIELDS; i++) begin : g_field_dec
        time_to_segment time_to_segment_inst (
            .value    (fields[i]),
            .seg_pair (seg_pairs[i])
        );
    end

    time_displayer #(
        .SCAN_DIV (SCAN_DIV)
    ) time_displayer_inst (
        .clk_src   (clk_src),
        .rst       (rst),
        .seg_pairs (seg_pairs),
        .anodes    (anodes),
        .cathodes  (cathodes)
    );

endmodule

// ==== rtl/time_displayer.sv ====
module time_displayer #(
    parameter int SCAN_DIV = 100_000
) (
    input  logic                                             clk_src,
    input  logic                                             rst,
    input  clock_pkg::seg_pair_t [clock_pkg::NUM_FIELDS-1:0] seg_pairs,
    output logic [clock_pkg::NUM_SLOTS-1:0]                  anodes,
    output clock_pkg::seg_t                                  cathodes
);

    // Enough bits to hold SCAN_DIV - 1
    localparam int HOLD_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(SCAN_DIV - 1);

    logic [HOLD_W-1:0]              hold;
    logic [clock_pkg::SLOT_W-1:0]   slot;
    logic [clock_pkg::NUM_SLOTS-1:0] slot_anodes;
    clock_pkg::seg_t                slot_cathodes;

    //////////////////////////////////////////////////
    // Slot sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge clk_src) begin
        if (rst) begin
            hold <= '0;
            slot <= '0;
        end else if (hold == HOLD_LAST) begin
            hold <= '0;
            // Wraps from 7 back to 0 on its own
            slot <= slot + 1'b1;
        end else begin
            hold <= hold + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Slot decode
    //////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < clock_pkg::NUM_SLOTS; k++) begin
            slot_anodes[k] = (slot != clock_pkg::SLOT_W'(k));
        end
    end

    // Even slot shows units, odd slot tens; slots past the fields stay dark
    always_comb begin
        slot_cathodes = clock_pkg::SEG_BLANK;
        for (int f = 0; f < clock_pkg::NUM_FIELDS; f++) begin
            if (slot == clock_pkg::SLOT_W'(2 * f)) begin
                slot_cathodes = seg_pairs[f][7:0];
            end
            if (slot == clock_pkg::SLOT_W'(2 * f + 1)) begin
                slot_cathodes = seg_pairs[f][15:8];
            end
        end
    end

    // Anodes and cathodes switch on the same edge to avoid ghosting
    always_ff @(posedge clk_src) begin
        if (rst) begin
            anodes   <= '1;
            cathodes <= clock_pkg::SEG_BLANK;
        end else begin
            anodes   <= slot_anodes;
            cathodes <= slot_cathodes;
        end
    end

    // One digit lit at a time once the scan has started
    one_anode_active: assert property (
        @(posedge clk_src)
        (!rst ##1 !rst) |-> $onehot(~anodes)
    ) else $error("anodes do not select exactly one digit");

endmodule

// ==== rtl/time_to_segment.sv ====
module time_to_segment (
    input  clock_pkg::time_val_t value,
    output clock_pkg::seg_pair_t seg_pair
);

    // Largest tens digit a 6-bit field can produce
    localparam int MAX_TENS = (2 ** $bits(clock_pkg::time_val_t) - 1) / 10;

    logic [3:0] tens;
    logic [3:0] units;
    clock_pkg::seg_t tens_seg;
    clock_pkg::seg_t units_seg;

    //////////////////////////////////////////////////
    // Split into two decimal digits
    //////////////////////////////////////////////////

    // Compare ladder instead of a full divider
    always_comb begin
        tens = '0;
        for (int t = 1; t <= MAX_TENS; t++) begin
            if (value >= clock_pkg::time_val_t'(10 * t)) begin
                tens = 4'(t);
            end
        end
    end

    assign units = 4'(value - clock_pkg::time_val_t'(10 * tens));

    //////////////////////////////////////////////////
    // Digit lookup
    //////////////////////////////////////////////////

    assign tens_seg  = clock_pkg::DIGIT_SEG[tens];
    assign units_seg = clock_pkg::DIGIT_SEG[units];

    // Units in the low byte for the even scan slot
    assign seg_pair = {tens_seg, units_seg};

endmodule

// ==== rtl/time_counter.sv ====
module time_counter (
    input  logic                                             clk_src,
    input  logic                                             rst,
    input  logic                                             tick,
    input  logic                                             set_valid,
    input  clock_pkg::time_val_t                             set_hour,
    input  clock_pkg::time_val_t                             set_min,
    input  clock_pkg::time_val_t                             set_sec,
    output logic                                             load,
    output clock_pkg::time_val_t [clock_pkg::NUM_FIELDS-1:0] fields
);

    logic set_in_range;
    logic sec_last;
    logic min_last;
    logic hour_last;

    //////////////////////////////////////////////////
    // Set request check
    //////////////////////////////////////////////////

    // All three values must be legal or the request is dropped
    assign set_in_range = (set_sec  <= clock_pkg::SEC_MAX) &&
                          (set_min  <= clock_pkg::MIN_MAX) &&
                          (set_hour <= clock_pkg::HOUR_MAX);

    // Also restarts the prescaler in the same cycle
    assign load = set_valid && set_in_range;

    //////////////////////////////////////////////////
    // Carry chain
    //////////////////////////////////////////////////

    assign sec_last  = (fields[clock_pkg::FIELD_SEC]  == clock_pkg::SEC_MAX);
    assign min_last  = (fields[clock_pkg::FIELD_MIN]  == clock_pkg::MIN_MAX);
    assign hour_last = (fields[clock_pkg::FIELD_HOUR] == clock_pkg::HOUR_MAX);

    always_ff @(posedge clk_src) begin
        if (rst) begin
            fields <= '0;
        end else if (load) begin
            // Load wins over a tick in the same cycle
            fields[clock_pkg::FIELD_SEC]  <= set_sec;
            fields[clock_pkg::FIELD_MIN]  <= set_min;
            fields[clock_pkg::FIELD_HOUR] <= set_hour;
        end else if (tick) begin
            if (!sec_last) begin
                fields[clock_pkg::FIELD_SEC] <=
                    fields[clock_pkg::FIELD_SEC] + clock_pkg::time_val_t'(1);
            end else begin
                fields[clock_pkg::FIELD_SEC] <= '0;
                if (!min_last) begin
                    fields[clock_pkg::FIELD_MIN] <=
                        fields[clock_pkg::FIELD_MIN] + clock_pkg::time_val_t'(1);
                end else begin
                    fields[clock_pkg::FIELD_MIN] <= '0;
                    // Midnight wrap
                    if (hour_last) begin
                        fields[clock_pkg::FIELD_HOUR] <= '0;
                    end else begin
                        fields[clock_pkg::FIELD_HOUR] <=
                            fields[clock_pkg::FIELD_HOUR] + clock_pkg::time_val_t'(1);
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Loads are screened and carries wrap, so no field may ever leave its range
    fields_in_range: assert property (
        @(posedge clk_src) disable iff (rst)
        (fields[clock_pkg::FIELD_SEC]  <= clock_pkg::SEC_MAX) &&
        (fields[clock_pkg::FIELD_MIN]  <= clock_pkg::MIN_MAX) &&
        (fields[clock_pkg::FIELD_HOUR] <= clock_pkg::HOUR_MAX)
    ) else $error("time field out of range");

endmodule

// ==== rtl/tick_prescaler.sv ====
module tick_prescaler #(
    parameter int TICK_DIV = 50_000_000
) (
    input  logic clk_src,
    input  logic rst,
    input  logic restart,
    output logic tick
);

    // Enough bits to hold TICK_DIV - 1
    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(TICK_DIV - 1);

    logic [CNT_W-1:0] count;

    // Last cycle of the current second
    assign tick = (count == '0);

    //////////////////////////////////////////////////
    // Down-counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk_src) begin
        if (rst) begin
            count <= RELOAD;
        end else if (restart) begin
            // A newly loaded time starts the second over
            count <= RELOAD;
        end else if (tick) begin
            count <= RELOAD;
        end else begin
            count <= count - 1'b1;
        end
    end

    // Seconds must never advance twice back to back
    tick_single_cycle: assert property (
        @(posedge clk_src) disable iff (rst)
        tick |=> !tick
    ) else $error("tick held high for more than one cycle");

endmodule

// ==== rtl/clock_pkg.sv ====
package clock_pkg;

    //////////////////////////////////////////////////
    // Field and display types
    //////////////////////////////////////////////////

    // One time field for hours, minutes or seconds
    typedef logic [5:0] time_val_t;

    // Active low with bit 0 as segment a, bit 6 as g and bit 7 the decimal point
    typedef logic [7:0] seg_t;

    // Tens pattern in the high byte, units pattern in the low byte
    typedef logic [15:0] seg_pair_t;

    //////////////////////////////////////////////////
    // Sizes and limits
    //////////////////////////////////////////////////

    localparam int NUM_FIELDS = 3;
    localparam int FIELD_SEC  = 0;
    localparam int FIELD_MIN  = 1;
    localparam int FIELD_HOUR = 2;

    localparam int NUM_SLOTS = 8;
    localparam int SLOT_W    = $clog2(NUM_SLOTS);

    localparam time_val_t SEC_MAX  = 6'd59;
    localparam time_val_t MIN_MAX  = 6'd59;
    localparam time_val_t HOUR_MAX = 6'd23;

    // All segments and the decimal point dark
    localparam seg_t SEG_BLANK = 8'hFF;

    // Digit patterns 0 to 9 with the decimal point held off
    // Codes 10 to 15 stay dark so any 4-bit digit is safe to look up
    localparam seg_t DIGIT_SEG [16] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99,
        8'h92, 8'h82, 8'hF8, 8'h80, 8'h90,
        8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF, 8'hFF
    };

endpackage
